// ==== source/fetchPkg.sv ====
package fetchPkg;

    // widths that carry a meaning
    typedef logic [31:0] addrT;
    typedef logic [31:0] wordT;
    typedef logic [4:0]  excCodeT;
    typedef logic [15:0] imm16T;
    typedef logic [25:0] jumpIndexT;

    // address map
    localparam addrT textStart  = 32'h0000_3000;
    localparam addrT textEnd    = 32'h0000_6FFC;
    localparam addrT ktextStart = 32'h0000_4180;
    // termination address, the PC parks here
    localparam addrT haltPc     = ktextStart - 32'd4;

    // exception codes
    localparam excCodeT excNone = 5'd0;
    localparam excCodeT excAdel = 5'd4;

    // control-flow class of the instruction in ID
    typedef enum logic [1:0] {
        flowSeq,
        flowBranch,
        flowJumpImm,
        flowJumpReg
    } flowKindT;

    // kernel control from CP0
    typedef enum logic [1:0] {
        kernelNone,
        kernelEnter,
        kernelEret
    } kernelCtrlT;

    // redirect request from decode and CP0
    typedef struct packed {
        flowKindT   kind;
        logic       branchTaken;
        imm16T      offset;
        jumpIndexT  jumpIndex;
        addrT       jumpTarget;
        kernelCtrlT kernel;
        addrT       epc;
    } redirectT;

    // IF/ID bundle
    typedef struct packed {
        logic    valid;
        wordT    code;
        addrT    pc;
        excCodeT exc;
        logic    branchDelay;
    } fetchBundleT;

    // fetch master states
    typedef enum logic [1:0] {
        stIdle,
        stBus,
        stHold
    } fetchStateT;

endpackage

// ==== source/nextPcLogic.sv ====
`timescale 1ns/10ps

module nextPcLogic (
    input  fetchPkg::addrT     pc,
    input  fetchPkg::redirectT redirect,
    output fetchPkg::addrT     nextPc
);
    import fetchPkg::*;

    addrT seqPc;
    addrT branchPc;
    addrT jumpImmPc;
    addrT eretPc;
    addrT branchDisp;
    logic halted;

    // pc here is the delay-slot address
    assign seqPc = pc + 32'd4;

    // sign-extended word offset
    assign branchDisp = {{14{redirect.offset[15]}}, redirect.offset, 2'b00};
    assign branchPc   = pc + branchDisp;

    // region bits of the delay slot joined with the index
    assign jumpImmPc = {pc[31:28], redirect.jumpIndex, 2'b00};

    // EPC is word aligned on return
    assign eretPc = {redirect.epc[31:2], 2'b00};

    assign halted = (pc == haltPc);

    always_comb begin
        if (halted) begin
            nextPc = haltPc;
        end else if (redirect.kernel == kernelEnter) begin
            nextPc = ktextStart;
        end else if (redirect.kernel == kernelEret) begin
            nextPc = eretPc;
        end else begin
            case (redirect.kind)
                flowJumpReg: begin
                    nextPc = redirect.jumpTarget;
                end
                flowJumpImm: begin
                    nextPc = jumpImmPc;
                end
                flowBranch: begin
                    // not-taken branch falls through
                    nextPc = redirect.branchTaken ? branchPc : seqPc;
                end
                default: begin
                    nextPc = seqPc;
                end
            endcase
        end
    end

    // decode must always hand over a defined class
    kindDefined: assert final (!$isunknown(redirect.kind)) else begin
        $error("nextPcLogic: undefined redirect kind %b", redirect.kind);
    end

endmodule

// ==== source/pcRegister.sv ====
`timescale 1ns/10ps

module pcRegister (
    input  logic              clk,
    input  logic              reset,
    input  logic              advance,
    input  fetchPkg::addrT    nextPc,
    output fetchPkg::addrT    pc,
    output fetchPkg::excCodeT pcExc
);
    import fetchPkg::*;

    logic outOfRange;
    logic misaligned;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= textStart;
        end else if (advance) begin
            pc <= nextPc;
        end
    end

    // legal fetch window
    assign outOfRange = (pc < textStart) || (pc > textEnd);
    assign misaligned = (pc[1:0] != 2'b00);

    assign pcExc = (outOfRange || misaligned) ? excAdel : excNone;

    // PC only moves on an accepted fetch
    pcHeld: assert property (
        @(posedge clk) disable iff (reset)
        !advance |=> $stable(pc)
    ) else begin
        $error("pcRegister: pc changed without advance");
    end

endmodule

// ==== source/wbFetchMaster.sv ====
`timescale 1ns/10ps

module wbFetchMaster (
    input  logic              clk,
    input  logic              reset,
    input  logic              stall,
    input  fetchPkg::addrT    pc,
    input  fetchPkg::excCodeT pcExc,
    input  fetchPkg::wordT    wbDatIn,
    input  logic              wbAck,
    output fetchPkg::addrT    wbAdr,
    output logic              wbCyc,
    output logic              wbStb,
    output logic              wbWe,
    output logic [3:0]        wbSel,
    output fetchPkg::wordT    fetchedCode,
    output logic              accept
);
    import fetchPkg::*;

    fetchStateT state;
    fetchStateT stateNext;
    logic       fetchReady;
    logic       addrError;

    assign addrError = (pcExc != excNone);

    always_comb begin
        stateNext = state;
        case (state)
            stIdle: begin
                // bad address never goes out on the bus
                stateNext = addrError ? stHold : stBus;
            end
            stBus: begin
                if (wbAck) begin
                    stateNext = stHold;
                end
            end
            stHold: begin
                if (!stall) begin
                    stateNext = stIdle;
                end
            end
            default: begin
                stateNext = stIdle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= stIdle;
        end else begin
            state <= stateNext;
        end
    end

    // fetched word, zero for an address error
    always_ff @(posedge clk) begin
        if (state == stIdle && addrError) begin
            fetchedCode <= '0;
        end else if (state == stBus && wbAck) begin
            fetchedCode <= wbDatIn;
        end
    end

    // single read in flight, PC is stable until accept
    assign wbCyc = (state == stBus);
    assign wbStb = (state == stBus);
    assign wbWe  = 1'b0;
    assign wbSel = 4'hF;
    assign wbAdr = pc;

    assign fetchReady = (state == stHold);
    assign accept     = fetchReady && !stall;

    // strobe only inside a cycle, and never for a faulting PC
    stbInCycle: assert property (
        @(posedge clk) disable iff (reset)
        wbStb |-> wbCyc && !addrError
    ) else begin
        $error("wbFetchMaster: strobe outside a cycle or on a bad address");
    end

    // open cycle keeps its request until acked
    cycleHeld: assert property (
        @(posedge clk) disable iff (reset)
        wbCyc && !wbAck |=> wbCyc && wbStb && $stable(wbAdr)
    ) else begin
        $error("wbFetchMaster: request dropped or address moved before ack");
    end

endmodule

// ==== source/fetchDecodeReg.sv ====
`timescale 1ns/10ps

module fetchDecodeReg (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 flush,
    input  logic                 load,
    input  fetchPkg::wordT       code,
    input  fetchPkg::addrT       pc,
    input  fetchPkg::excCodeT    exc,
    input  fetchPkg::redirectT   redirect,
    output fetchPkg::fetchBundleT toDecode
);
    import fetchPkg::*;

    fetchBundleT bundleIn;

    // redirect describes the instruction now in ID, so a
    // non-sequential kind marks the word being loaded as a delay slot
    always_comb begin
        bundleIn.valid       = 1'b1;
        bundleIn.code        = code;
        bundleIn.pc          = pc;
        bundleIn.exc         = exc;
        bundleIn.branchDelay = (redirect.kind != flowSeq);
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            // bubble
            toDecode <= '0;
        end else if (load) begin
            toDecode <= bundleIn;
        end
    end

    // fetch master zeroes the word on an address error
    excCarriesNoCode: assert property (
        @(posedge clk) disable iff (reset)
        toDecode.valid && (toDecode.exc != excNone) |-> (toDecode.code == '0)
    ) else begin
        $error("fetchDecodeReg: exception bundle with nonzero code %h", toDecode.code);
    end

endmodule

// ==== source/fetchStage.sv ====
`timescale 1ns/10ps

module fetchStage (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  stall,
    input  logic                  flush,
    input  fetchPkg::redirectT    redirect,
    input  fetchPkg::wordT        wbDatIn,
    input  logic                  wbAck,
    output fetchPkg::addrT        wbAdr,
    output logic                  wbCyc,
    output logic                  wbStb,
    output logic                  wbWe,
    output logic [3:0]            wbSel,
    output fetchPkg::fetchBundleT toDecode,
    output fetchPkg::addrT        fetchPc
);
    import fetchPkg::*;

    addrT    pc;
    addrT    nextPc;
    excCodeT pcExc;
    wordT    fetchedCode;
    logic    accept;

    assign fetchPc = pc;

    nextPcLogic nextPcLogic (
        .pc       (pc),
        .redirect (redirect),
        .nextPc   (nextPc)
    );

    // advances once per accepted fetch
    pcRegister pcRegister (
        .clk     (clk),
        .reset   (reset),
        .advance (accept),
        .nextPc  (nextPc),
        .pc      (pc),
        .pcExc   (pcExc)
    );

    wbFetchMaster wbFetchMaster (
        .clk         (clk),
        .reset       (reset),
        .stall       (stall),
        .pc          (pc),
        .pcExc       (pcExc),
        .wbDatIn     (wbDatIn),
        .wbAck       (wbAck),
        .wbAdr       (wbAdr),
        .wbCyc       (wbCyc),
        .wbStb       (wbStb),
        .wbWe        (wbWe),
        .wbSel       (wbSel),
        .fetchedCode (fetchedCode),
        .accept      (accept)
    );

    fetchDecodeReg fetchDecodeReg (
        .clk      (clk),
        .reset    (reset),
        .flush    (flush),
        .load     (accept),
        .code     (fetchedCode),
        .pc       (pc),
        .exc      (pcExc),
        .redirect (redirect),
        .toDecode (toDecode)
    );

endmodule

// ==== dv/fetchTbTasks.svh ====
`ifndef fetchTbTasksSvh
`define fetchTbTasksSvh

// value fills whichever field the kind or kernel request reads
function automatic redirectT makeRedirect(input flowKindT kind, input logic taken,
                                          input logic [31:0] value, input kernelCtrlT kernel);
    redirectT r;
    r.kind        = kind;
    r.branchTaken = taken;
    r.offset      = value[15:0];
    r.jumpIndex   = value[25:0];
    r.jumpTarget  = value;
    r.kernel      = kernel;
    r.epc         = value;
    return r;
endfunction

function automatic redirectT seqRedirect();
    return makeRedirect(flowSeq, 1'b0, 32'd0, kernelNone);
endfunction

function automatic logic fetchable(input addrT pc);
    return pc >= textStart && pc <= textEnd && pc[1:0] == 2'b00;
endfunction

// next PC from the delay-slot address and the redirect
function automatic addrT predictNext(input addrT pc, input redirectT r);
    logic signed [31:0] disp;
    disp = $signed(r.offset);
    disp = disp <<< 2;
    if (pc == haltPc) return haltPc;
    if (r.kernel == kernelEnter) return ktextStart;
    if (r.kernel == kernelEret) return r.epc & 32'hFFFF_FFFC;
    if (r.kind == flowJumpReg) return r.jumpTarget;
    if (r.kind == flowJumpImm) return {pc[31:28], r.jumpIndex, 2'b00};
    if (r.kind == flowBranch && r.branchTaken) return pc + disp;
    return pc + 32'd4;
endfunction

// one accepted fetch, then check the new bundle and the bus
task automatic stepFetch(input redirectT r, output fetchBundleT got);
    addrT fetched;
    logic legal;
    fetched = expPc;
    legal = fetchable(fetched);
    redirect = r;
    // accept marks the edge that loads ID and the PC
    do begin
        @(posedge clk);
    end while (!DUT.accept);
    @(negedge clk);
    got = toDecode;
    compareWord("bundle valid", got.valid, 1);
    compareWord("bundle pc", got.pc, fetched);
    compareWord("bundle code", got.code, legal ? fetched ^ codeMask : 32'd0);
    compareWord("bundle exc", got.exc, legal ? 32'd0 : 32'd4);
    compareWord("branchDelay", got.branchDelay, r.kind != flowSeq);
    if (legal) begin
        compareWord("bus reads", busAddrs.size(), busIndex + 1);
        if (busAddrs.size() > busIndex) begin
            compareWord("bus address", busAddrs[busIndex], fetched);
        end
        busIndex = busAddrs.size();
    end else begin
        // no cycle may open for a bad address
        compareWord("bus reads on address error", busAddrs.size(), busIndex);
    end
    expPc = predictNext(fetched, r);
    compareWord("fetchPc", fetchPc, expPc);
endtask

task automatic sequentialTest();
    fetchBundleT got;
    for (int i = 0; i < 20; i++) begin
        stepFetch(seqRedirect(), got);
        compareWord("sequential pc", got.pc, textStart + 4 * i);
    end
endtask

task automatic branchTest();
    fetchBundleT got;
    addrT slotPc;
    stepFetch(seqRedirect(), got);
    slotPc = expPc;
    stepFetch(makeRedirect(flowBranch, 1'b1, 32'h0000_0010, kernelNone), got);
    stepFetch(seqRedirect(), got);
    compareWord("forward branch target", got.pc, slotPc + 32'h40);
    slotPc = expPc;
    stepFetch(makeRedirect(flowBranch, 1'b1, 32'h0000_FFF8, kernelNone), got);
    stepFetch(seqRedirect(), got);
    compareWord("backward branch target", got.pc, slotPc - 32'h20);
    slotPc = expPc;
    // not taken, still a delay slot
    stepFetch(makeRedirect(flowBranch, 1'b0, 32'h0000_0100, kernelNone), got);
    stepFetch(seqRedirect(), got);
    compareWord("branch not taken", got.pc, slotPc + 32'h4);
endtask

task automatic jumpTest();
    fetchBundleT got;
    stepFetch(seqRedirect(), got);
    stepFetch(makeRedirect(flowJumpImm, 1'b0, 32'h0000_0D00, kernelNone), got);
    stepFetch(seqRedirect(), got);
    compareWord("immediate jump target", got.pc, 32'h0000_3400);
    stepFetch(makeRedirect(flowJumpReg, 1'b0, 32'h0000_3800, kernelNone), got);
    stepFetch(seqRedirect(), got);
    compareWord("register jump target", got.pc, 32'h0000_3800);
endtask

task automatic stallFlushTest();
    fetchBundleT got;
    fetchBundleT held;
    addrT heldPc;
    stepFetch(seqRedirect(), got);
    held = toDecode;
    heldPc = fetchPc;
    stall = 1'b1;
    repeat (8) begin
        @(negedge clk);
        assert (toDecode === held && fetchPc === heldPc) else begin
            $display("Fail at %0t: toDecode or fetchPc moved under stall", $time);
            errorCount++;
        end
    end
    stall = 1'b0;
    stepFetch(seqRedirect(), got);
    flush = 1'b1;
    @(negedge clk);
    flush = 1'b0;
    // a bubble clears every field
    assert (toDecode === '0) else begin
        $display("Fail at %0t: flushed bundle is %h, expected all zero", $time, toDecode);
        errorCount++;
    end
    stepFetch(seqRedirect(), got);
    stepFetch(seqRedirect(), got);
endtask

task automatic addressErrorTest();
    fetchBundleT got;
    stepFetch(makeRedirect(flowJumpReg, 1'b0, 32'h0000_3102, kernelNone), got);
    stepFetch(makeRedirect(flowJumpReg, 1'b0, 32'h0000_3200, kernelNone), got);
    compareWord("misaligned fetch exc", got.exc, 32'd4);
    compareWord("misaligned fetch code", got.code, 32'd0);
    stepFetch(makeRedirect(flowJumpReg, 1'b0, 32'h0000_7000, kernelNone), got);
    stepFetch(makeRedirect(flowJumpReg, 1'b0, 32'h0000_3300, kernelNone), got);
    compareWord("out of range fetch exc", got.exc, 32'd4);
    stepFetch(seqRedirect(), got);
    compareWord("pc after address error", got.pc, 32'h0000_3300);
endtask

task automatic kernelHaltTest();
    fetchBundleT got;
    stepFetch(makeRedirect(flowSeq, 1'b0, 32'd0, kernelEnter), got);
    stepFetch(seqRedirect(), got);
    compareWord("kernel entry pc", got.pc, 32'h0000_4180);
    stepFetch(makeRedirect(flowSeq, 1'b0, 32'h0000_3457, kernelEret), got);
    stepFetch(seqRedirect(), got);
    compareWord("exception return pc", got.pc, 32'h0000_3454);
    stepFetch(makeRedirect(flowJumpReg, 1'b0, 32'h0000_417C, kernelNone), got);
    repeat (3) begin
        stepFetch(seqRedirect(), got);
        compareWord("halted pc", got.pc, 32'h0000_417C);
    end
    // a jump while parked must not move the PC
    stepFetch(makeRedirect(flowJumpReg, 1'b0, textStart, kernelNone), got);
    stepFetch(seqRedirect(), got);
    compareWord("halted pc after jump", got.pc, 32'h0000_417C);
endtask

`endif

// ==== dv/fetchStageTb.sv ====
`timescale 1ns/10ps

module fetchStageTb;
    import fetchPkg::*;

    localparam int   cycleLimit = 3000;
    localparam wordT codeMask   = 32'hA5A5_0000;

    logic        clk;
    logic        reset;
    logic        stall;
    logic        flush;
    redirectT    redirect;
    wordT        wbDatIn;
    logic        wbAck;
    addrT        wbAdr;
    logic        wbCyc;
    logic        wbStb;
    logic        wbWe;
    logic [3:0]  wbSel;
    fetchBundleT toDecode;
    addrT        fetchPc;

    logic [15:0] lfsrState = 16'd41161;
    int          errorCount = 0;
    int          cycleCount = 0;
    int          waitLeft;
    logic        slaveBusy;
    logic [3:0]  drawn;
    // every address the slave saw, in order
    addrT        busAddrs[$];
    int          busIndex;
    // PC the DUT should be fetching now
    addrT        expPc;

    fetchStage DUT (
        .clk      (clk),
        .reset    (reset),
        .stall    (stall),
        .flush    (flush),
        .redirect (redirect),
        .wbDatIn  (wbDatIn),
        .wbAck    (wbAck),
        .wbAdr    (wbAdr),
        .wbCyc    (wbCyc),
        .wbStb    (wbStb),
        .wbWe     (wbWe),
        .wbSel    (wbSel),
        .toDecode (toDecode),
        .fetchPc  (fetchPc)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsrNext(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    task automatic takeRandomBits(input int count, output logic [3:0] bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            bits = {bits[2:0], lfsrState[0]};
        end
    endtask

    task automatic compareWord(input string what, input logic [31:0] got,
                               input logic [31:0] want);
        assert (got === want) else begin
            $display("Fail at %0t: %s is %h, expected %h", $time, what, got, want);
            errorCount++;
        end
    endtask

    // instruction memory slave, 0 to 3 wait states
    always @(negedge clk) begin
        if (reset) begin
            wbAck = 1'b0;
            slaveBusy = 1'b0;
        end else if (wbAck) begin
            wbAck = 1'b0;
        end else if (wbCyc && wbStb) begin
            if (!slaveBusy) begin
                slaveBusy = 1'b1;
                busAddrs.push_back(wbAdr);
                compareWord("read-only bus controls", {wbWe, wbSel}, 5'b0_1111);
                takeRandomBits(2, drawn);
                waitLeft = drawn;
            end
            if (waitLeft == 0) begin
                wbAck = 1'b1;
                wbDatIn = wbAdr ^ codeMask;
                slaveBusy = 1'b0;
            end else begin
                waitLeft--;
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    `include "fetchTbTasks.svh"

    initial begin
        reset = 1'b1;
        stall = 1'b0;
        flush = 1'b0;
        redirect = '0;
        wbAck = 1'b0;
        wbDatIn = '0;
        busIndex = 0;
        expPc = textStart;
        repeat (3) @(negedge clk);
        reset = 1'b0;

        sequentialTest();
        branchTest();
        jumpTest();
        stallFlushTest();
        addressErrorTest();
        // halt is permanent, so it goes last
        kernelHaltTest();

        $display("errors: %0d", errorCount);
        if (errorCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+dv
source/fetchPkg.sv
source/nextPcLogic.sv
source/pcRegister.sv
source/wbFetchMaster.sv
source/fetchDecodeReg.sv
source/fetchStage.sv
dv/fetchStageTb.sv

// ==== Bender.yml ====
package:
  name: fetch_stage

sources:
  - source/fetchPkg.sv
  - source/nextPcLogic.sv
  - source/pcRegister.sv
  - source/wbFetchMaster.sv
  - source/fetchDecodeReg.sv
  - source/fetchStage.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/fetchStageTb.sv
